// ==== cpu.f ====
verilog/cpu_isa_pkg.sv
verilog/cpu_mem_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_pc_control.sv
verilog/cpu_byte_load.sv
verilog/cpu_debug_port.sv
verilog/cpu_data_mem.sv
verilog/cpu.sv
sim/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f cpu.f

out=$(./obj_dir/Vcpu_tb)
echo "$out"

# Exit status comes from the search for the pass line
echo "$out" | grep -q "Simulation PASSED"

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;
	import cpu_isa_pkg::*;
	import cpu_mem_pkg::*;

	localparam int NUM_PROGS   = 20;
	localparam int MAX_INSTR   = 60;
	localparam int APB_CYCLES  = 2 * (4 * NUM_REGS + 2 * MAX_INSTR + 2 * DMEM_WORDS);
	localparam int PROG_CYCLES = 12 + APB_CYCLES + MAX_INSTR + 8;
	localparam int TIMEOUT     = NUM_PROGS * PROG_CYCLES + 1000;

	logic      clk;
	logic      rst_n_i;
	logic      run_i;
	apb_addr_t paddr_i;
	logic      psel_i;
	logic      penable_i;
	logic      pwrite_i;
	word_t     pwdata_i;
	word_t     prdata_o;
	word_t     pc_o;
	logic      hlt_o;

	word_t      prog [IMEM_WORDS];
	logic [1:0] slot [IMEM_WORDS]; // 1 for a B, 2 for the head of an LLB/LHB/BR group
	logic       forbid [IMEM_WORDS];
	word_t      m_reg [NUM_REGS];
	word_t      m_dmem [DMEM_WORDS];
	word_t      m_pc;
	logic       m_z;
	logic       m_v;
	logic       m_n;
	int         err_flow = 0;
	int         err_reg = 0;
	int         err_mem = 0;
	int         cycles = 0;

	cpu i_cpu (
		.clk(clk), .rst_n_i(rst_n_i), .run_i(run_i), .paddr_i(paddr_i), .psel_i(psel_i),
		.penable_i(penable_i), .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pc_o(pc_o), .hlt_o(hlt_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, the test did not reach its end", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic apb_write(input apb_addr_t addr, input word_t data);
		@(negedge clk);
		paddr_i   = addr;
		pwrite_i  = 1'b1;
		pwdata_i  = data;
		psel_i    = 1'b1;
		penable_i = 1'b0;
		@(negedge clk);
		penable_i = 1'b1;
		@(posedge clk); // Write lands here
	endtask

	task automatic apb_read(input apb_addr_t addr, output word_t data);
		@(negedge clk);
		paddr_i   = addr;
		pwrite_i  = 1'b0;
		psel_i    = 1'b1;
		penable_i = 1'b0;
		@(negedge clk);
		penable_i = 1'b1;
		@(posedge clk);
		data = prdata_o;
	endtask

	task automatic apb_idle();
		@(negedge clk);
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	task automatic gen_program(input int n);
		int i;
		int t;
		int kind;
		for (i = 0; i < n; i++) begin
			slot[i]   = 2'd0;
			forbid[i] = 1'b0;
		end
		i = 0;
		while (i < n - 1) begin
			kind = int'($urandom % 15);
			if (kind == 13 && i + 2 < n - 1) begin
				slot[i]       = 2'd2;
				forbid[i + 1] = 1'b1; // Never land between LLB and BR
				forbid[i + 2] = 1'b1;
				prog[i + 2]   = {4'hD, 3'($urandom), 1'b0, 4'hF, 4'h0};
				i += 3;
			end else begin
				if (kind == 12) begin
					slot[i] = 2'd1;
				end else if (kind == 13) begin
					prog[i] = {4'h0, 12'($urandom)};
				end else begin
					prog[i] = {4'(kind), 12'($urandom)};
				end
				i++;
			end
		end
		prog[n - 1] = 16'hF000;
		// Targets are picked once the layout is fixed
		for (i = 0; i < n - 1; i++) begin
			if (slot[i] == 2'd1) begin
				t = i + 1 + int'($urandom % (n - 1 - i));
				while (forbid[t]) t++;
				prog[i] = {4'hC, 3'($urandom), 9'(t - i - 1)};
			end else if (slot[i] == 2'd2) begin
				t = i + 3 + int'($urandom % (n - 3 - i));
				while (forbid[t]) t++;
				prog[i]     = {4'hA, 4'hF, 8'(2 * t)};
				prog[i + 1] = {4'hB, 4'hF, 8'((2 * t) >> 8)};
			end
		end
	endtask

	function automatic word_t clamp16(input int s);
		if (s > 32767) return 16'h7fff;
		if (s < -32768) return 16'h8000;
		return 16'(s);
	endfunction

	function automatic logic cond_met(input logic [2:0] cc);
		case (cc)
			3'd0: return !m_z;
			3'd1: return m_z;
			3'd2: return !m_z && !m_n;
			3'd3: return m_n;
			3'd4: return m_z || !m_n;
			3'd5: return m_n || m_z;
			3'd6: return m_v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic write_reg(input reg_idx_t r, input word_t v);
		if (r != 4'h0) m_reg[r] = v;
	endtask

	task automatic model_step();
		word_t      ins;
		word_t      a;
		word_t      b;
		word_t      res;
		word_t      addr;
		word_t      nxt;
		int         s;
		int         k;
		logic [3:0] op;
		ins  = prog[m_pc[8:1]];
		op   = ins[15:12];
		a    = m_reg[ins[7:4]];
		b    = m_reg[ins[3:0]];
		addr = a + {{11{ins[3]}}, ins[3:0], 1'b0};
		nxt  = m_pc + 16'd2;
		res  = a;
		case (op)
			4'h0, 4'h1: begin
				if (op == 4'h0) s = int'($signed(a)) + int'($signed(b));
				else s = int'($signed(a)) - int'($signed(b));
				res = clamp16(s);
				m_v = (s > 32767) || (s < -32768);
				m_n = res[15];
				m_z = (res == 16'h0);
				write_reg(ins[11:8], res);
			end
			4'h2, 4'h4, 4'h5, 4'h6: begin
				if (op == 4'h2) begin
					res = a ^ b;
				end else if (op == 4'h4) begin
					res = a << ins[3:0];
				end else begin
					for (k = 0; k < int'(ins[3:0]); k++) begin
						if (op == 4'h5) res = {res[15], res[15:1]};
						else res = {res[0], res[15:1]};
					end
				end
				m_z = (res == 16'h0);
				write_reg(ins[11:8], res);
			end
			4'h7: begin
				for (k = 0; k < 4; k++) begin
					s = int'($signed(a[4*k +: 4])) + int'($signed(b[4*k +: 4]));
					if (s > 7) s = 7;
					else if (s < -8) s = -8;
					res[4*k +: 4] = 4'(s);
				end
				write_reg(ins[11:8], res);
			end
			4'h8: write_reg(ins[11:8], m_dmem[addr[8:1]]);
			4'h9: m_dmem[addr[8:1]] = m_reg[ins[11:8]];
			4'hA: write_reg(ins[11:8], {m_reg[ins[11:8]][15:8], ins[7:0]});
			4'hB: write_reg(ins[11:8], {ins[7:0], m_reg[ins[11:8]][7:0]});
			4'hC: if (cond_met(ins[11:9])) nxt = nxt + {{6{ins[8]}}, ins[8:0], 1'b0};
			4'hD: if (cond_met(ins[11:9])) nxt = a;
			4'hE: write_reg(ins[11:8], nxt);
			default: ;
		endcase
		m_pc = nxt;
	endtask

	task automatic run_program();
		logic m_hlt;
		logic done;
		done = 1'b0;
		@(negedge clk);
		run_i = 1'b1;
		while (!done) begin
			m_hlt = (prog[m_pc[8:1]][15:12] == 4'hF);
			if (pc_o !== m_pc) begin
				err_flow++;
				$display("Fail at %0t: pc_o expected %h actual %h", $time, m_pc, pc_o);
			end
			if (hlt_o !== m_hlt) begin
				err_flow++;
				$display("Fail at %0t: hlt_o expected %b actual %b", $time, m_hlt, hlt_o);
			end
			if (m_hlt) begin
				done = 1'b1;
			end else begin
				model_step();
				@(negedge clk);
			end
		end
		repeat (5) begin
			@(negedge clk);
			if (pc_o !== m_pc) begin
				err_flow++;
				$display("Fail at %0t: pc_o expected %h actual %h", $time, m_pc, pc_o);
			end
			if (hlt_o !== 1'b1) begin
				err_flow++;
				$display("Fail at %0t: hlt_o expected 1 actual %b", $time, hlt_o);
			end
		end
		run_i = 1'b0;
	endtask

	initial begin
		int    n;
		word_t d;
		rst_n_i   = 1'b0;
		run_i     = 1'b0;
		paddr_i   = '0;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		pwdata_i  = '0;
		void'($urandom(91705));
		for (int p = 0; p < NUM_PROGS; p++) begin
			n = 10 + int'($urandom % (MAX_INSTR - 9));
			gen_program(n);
			@(negedge clk);
			rst_n_i = 1'b0;
			repeat (10) @(negedge clk);
			rst_n_i = 1'b1;
			if (pc_o !== 16'h0) begin
				err_flow++;
				$display("Fail at %0t: pc_o expected 0000 actual %h", $time, pc_o);
			end
			for (int r = 0; r < NUM_REGS; r++) begin
				apb_read(APB_REG_BASE + apb_addr_t'(r), d);
				if (d !== 16'h0) begin
					err_reg++;
					$display("Fail at %0t: r%0d after reset expected 0000 actual %h", $time, r, d);
				end
			end
			for (int k = 0; k < n; k++) begin
				apb_write(APB_IMEM_BASE + apb_addr_t'(k), prog[k]);
			end
			for (int k = 0; k < DMEM_WORDS; k++) begin
				m_dmem[k] = word_t'($urandom);
				apb_write(APB_DMEM_BASE + apb_addr_t'(k), m_dmem[k]);
			end
			for (int k = 0; k < n; k++) begin
				apb_read(APB_IMEM_BASE + apb_addr_t'(k), d);
				if (d !== prog[k]) begin
					err_mem++;
					$display("Fail at %0t: imem[%0d] expected %h actual %h", $time, k, prog[k], d);
				end
			end
			apb_idle();
			for (int r = 0; r < NUM_REGS; r++) m_reg[r] = 16'h0;
			m_pc = 16'h0;
			m_z  = 1'b0;
			m_v  = 1'b0;
			m_n  = 1'b0;
			run_program();
			for (int r = 0; r < NUM_REGS; r++) begin
				apb_read(APB_REG_BASE + apb_addr_t'(r), d);
				if (d !== m_reg[r]) begin
					err_reg++;
					$display("Fail at %0t: r%0d expected %h actual %h", $time, r, m_reg[r], d);
				end
			end
			for (int k = 0; k < DMEM_WORDS; k++) begin
				apb_read(APB_DMEM_BASE + apb_addr_t'(k), d);
				if (d !== m_dmem[k]) begin
					err_mem++;
					$display("Fail at %0t: dmem[%0d] expected %h actual %h", $time, k, m_dmem[k], d);
				end
			end
			apb_idle();
		end
		$display("Errors: flow %0d, register %0d, memory %0d", err_flow, err_reg, err_mem);
		if (err_flow + err_reg + err_mem == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ns

module cpu (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   run_i,
	input  cpu_mem_pkg::apb_addr_t paddr_i,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  cpu_isa_pkg::word_t     pwdata_i,
	output cpu_isa_pkg::word_t     prdata_o,
	output cpu_isa_pkg::word_t     pc_o,
	output logic                   hlt_o
);
	import cpu_isa_pkg::*;

	word_t    instr;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	reg_idx_t rd_idx;
	reg_idx_t dbg_reg_idx;
	word_t    imm;
	imm8_t    byte_val;
	br_off_t  br_off;
	ccode_e   ccode;
	opcode_e  opcode;
	wb_sel_t  wb_sel;
	logic     reg_we;
	logic     flag_we;
	logic     alu_src_imm;
	logic     mem_we;
	logic     retire;
	logic     dmem_dbg_we;
	word_t    rs_data;
	word_t    rt_data;
	word_t    wdata;
	word_t    alu_b;
	word_t    alu_result;
	word_t    alu_addr;
	word_t    mem_rdata;
	word_t    pc_plus2;
	word_t    dmem_dbg_rdata;
	word_t    dbg_reg_data;
	flags_t   alu_flags;
	flags_t   flags_q;

	assign retire = run_i && !hlt_o; // One instruction per edge
	assign alu_b  = alu_src_imm ? imm : rt_data;

	cpu_debug_port i_debug_port (
		.clk(clk), .rst_n_i(rst_n_i), .run_i(run_i), .paddr_i(paddr_i), .psel_i(psel_i),
		.penable_i(penable_i), .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pc_i(pc_o), .instr_o(instr), .dmem_we_o(dmem_dbg_we), .dmem_rdata_i(dmem_dbg_rdata),
		.reg_idx_o(dbg_reg_idx), .reg_data_i(dbg_reg_data)
	);

	cpu_decode i_decode (
		.instr_i(instr), .rs_o(rs_idx), .rt_o(rt_idx), .rd_o(rd_idx), .imm_o(imm),
		.byte_o(byte_val), .br_off_o(br_off), .ccode_o(ccode), .opcode_o(opcode),
		.reg_we_o(reg_we), .flag_we_o(flag_we), .alu_src_imm_o(alu_src_imm),
		.mem_we_o(mem_we), .hlt_o(hlt_o), .wb_sel_o(wb_sel)
	);

	cpu_regfile i_regfile (
		.clk(clk), .rst_n_i(rst_n_i), .rs_i(rs_idx), .rt_i(rt_idx), .rd_i(rd_idx),
		.we_i(reg_we && retire), .wdata_i(wdata), .dbg_idx_i(dbg_reg_idx),
		.rs_data_o(rs_data), .rt_data_o(rt_data), .dbg_data_o(dbg_reg_data)
	);

	cpu_alu i_alu (
		.opcode_i(opcode), .a_i(rs_data), .b_i(alu_b),
		.result_o(alu_result), .addr_o(alu_addr), .flags_o(alu_flags)
	);

	cpu_byte_load i_byte_load (
		.opcode_i(opcode), .wb_sel_i(wb_sel), .rd_data_i(rs_data), .byte_i(byte_val),
		.alu_i(alu_result), .mem_i(mem_rdata), .pcs_i(pc_plus2), .wdata_o(wdata)
	);

	cpu_pc_control i_pc_control (
		.clk(clk), .rst_n_i(rst_n_i), .en_i(retire), .opcode_i(opcode), .ccode_i(ccode),
		.flags_i(flags_q), .br_off_i(br_off), .rs_data_i(rs_data),
		.pc_o(pc_o), .pc_plus2_o(pc_plus2)
	);

	cpu_data_mem i_data_mem (
		.clk(clk), .addr_i(alu_addr[8:1]), .wdata_i(rt_data), .we_i(mem_we && retire),
		.rdata_o(mem_rdata), .dbg_addr_i(paddr_i[7:0]), .dbg_wdata_i(pwdata_i),
		.dbg_we_i(dmem_dbg_we), .dbg_rdata_o(dmem_dbg_rdata)
	);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			flags_q <= '0;
		end else if (retire && flag_we) begin
			flags_q[FLAG_Z] <= alu_flags[FLAG_Z];
			if (opcode == OP_ADD || opcode == OP_SUB) begin
				flags_q[FLAG_V] <= alu_flags[FLAG_V]; // Logic and shift ops keep V and N
				flags_q[FLAG_N] <= alu_flags[FLAG_N];
			end
		end
	end

endmodule

// ==== verilog/cpu_data_mem.sv ====
`timescale 1ns/1ns

module cpu_data_mem (
	input  logic                  clk,
	input  cpu_mem_pkg::mem_idx_t addr_i,
	input  cpu_isa_pkg::word_t    wdata_i,
	input  logic                  we_i,
	output cpu_isa_pkg::word_t    rdata_o,
	input  cpu_mem_pkg::mem_idx_t dbg_addr_i,
	input  cpu_isa_pkg::word_t    dbg_wdata_i,
	input  logic                  dbg_we_i,
	output cpu_isa_pkg::word_t    dbg_rdata_o
);
	import cpu_isa_pkg::*;
	import cpu_mem_pkg::*;

	word_t mem [DMEM_WORDS];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end else if (dbg_we_i) begin
			mem[dbg_addr_i] <= dbg_wdata_i;
		end
	end

	assign rdata_o     = mem[addr_i];
	assign dbg_rdata_o = mem[dbg_addr_i];

	// Core runs and APB loads never overlap
	a_one_writer: assert property (@(posedge clk) !(we_i && dbg_we_i));

endmodule

// ==== verilog/cpu_debug_port.sv ====
`timescale 1ns/1ns

module cpu_debug_port (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   run_i,
	input  cpu_mem_pkg::apb_addr_t paddr_i,
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  cpu_isa_pkg::word_t     pwdata_i,
	output cpu_isa_pkg::word_t     prdata_o,
	input  cpu_isa_pkg::word_t     pc_i,
	output cpu_isa_pkg::word_t     instr_o,
	output logic                   dmem_we_o,
	input  cpu_isa_pkg::word_t     dmem_rdata_i,
	output cpu_isa_pkg::reg_idx_t  reg_idx_o,
	input  cpu_isa_pkg::word_t     reg_data_i
);
	import cpu_isa_pkg::*;
	import cpu_mem_pkg::*;

	word_t    imem [IMEM_WORDS];
	mem_idx_t apb_idx;
	logic     sel_imem;
	logic     sel_dmem;
	logic     sel_reg;
	logic     wr_access;

	assign apb_idx   = paddr_i[MEM_IDX_W-1:0];
	assign sel_imem  = paddr_i[APB_ADDR_W-1:MEM_IDX_W] == APB_IMEM_BASE[APB_ADDR_W-1:MEM_IDX_W];
	assign sel_dmem  = paddr_i[APB_ADDR_W-1:MEM_IDX_W] == APB_DMEM_BASE[APB_ADDR_W-1:MEM_IDX_W];
	assign sel_reg   = paddr_i[APB_ADDR_W-1:MEM_IDX_W] == APB_REG_BASE[APB_ADDR_W-1:MEM_IDX_W];
	assign wr_access = psel_i && penable_i && pwrite_i;

	always_ff @(posedge clk) begin
		if (wr_access && sel_imem) begin
			imem[apb_idx] <= pwdata_i;
		end
	end

	assign instr_o   = imem[pc_i[MEM_IDX_W:1]]; // Word fetch from byte pc
	assign dmem_we_o = wr_access && sel_dmem;
	assign reg_idx_o = paddr_i[REG_IDX_W-1:0];

	always_comb begin
		prdata_o = '0;
		if (psel_i && !pwrite_i) begin
			if (sel_imem) begin
				prdata_o = imem[apb_idx];
			end else if (sel_dmem) begin
				prdata_o = dmem_rdata_i;
			end else if (sel_reg) begin
				prdata_o = reg_data_i;
			end
		end
	end

	a_apb_stopped: assert property (@(posedge clk) disable iff (!rst_n_i) psel_i |-> !run_i);

endmodule

// ==== verilog/cpu_byte_load.sv ====
`timescale 1ns/1ns

module cpu_byte_load (
	input  cpu_isa_pkg::opcode_e opcode_i,
	input  cpu_isa_pkg::wb_sel_t wb_sel_i,
	input  cpu_isa_pkg::word_t   rd_data_i,
	input  cpu_isa_pkg::imm8_t   byte_i,
	input  cpu_isa_pkg::word_t   alu_i,
	input  cpu_isa_pkg::word_t   mem_i,
	input  cpu_isa_pkg::word_t   pcs_i,
	output cpu_isa_pkg::word_t   wdata_o
);
	import cpu_isa_pkg::*;

	word_t llb;
	word_t lhb;
	word_t byte_res;

	assign llb = {rd_data_i[WORD_W-1:BYTE_W], byte_i};
	assign lhb = {byte_i, rd_data_i[BYTE_W-1:0]};

	assign byte_res = (opcode_i == OP_LHB) ? lhb : llb;

	always_comb begin
		case (wb_sel_i)
			WB_MEM:  wdata_o = mem_i;
			WB_PCS:  wdata_o = pcs_i; // Return address
			WB_BYTE: wdata_o = byte_res;
			default: wdata_o = alu_i;
		endcase
	end

endmodule

// ==== verilog/cpu_pc_control.sv ====
`timescale 1ns/1ns

module cpu_pc_control (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 en_i,
	input  cpu_isa_pkg::opcode_e opcode_i,
	input  cpu_isa_pkg::ccode_e  ccode_i,
	input  cpu_isa_pkg::flags_t  flags_i,
	input  cpu_isa_pkg::br_off_t br_off_i,
	input  cpu_isa_pkg::word_t   rs_data_i,
	output cpu_isa_pkg::word_t   pc_o,
	output cpu_isa_pkg::word_t   pc_plus2_o
);
	import cpu_isa_pkg::*;

	word_t pc_q;
	word_t br_target;
	word_t pc_next;
	logic  taken;
	logic  z;
	logic  v;
	logic  n;

	assign z = flags_i[FLAG_Z];
	assign v = flags_i[FLAG_V];
	assign n = flags_i[FLAG_N];

	always_comb begin
		case (ccode_i)
			CC_NE:   taken = !z;
			CC_EQ:   taken = z;
			CC_GT:   taken = !z && !n;
			CC_LT:   taken = n;
			CC_GTE:  taken = z || !n;
			CC_LTE:  taken = n || z;
			CC_OVF:  taken = v;
			default: taken = 1'b1;
		endcase
	end

	assign pc_plus2_o = pc_q + 16'd2;
	assign br_target  = pc_plus2_o + {{(WORD_W-BR_OFF_W-1){br_off_i[BR_OFF_W-1]}}, br_off_i, 1'b0};

	always_comb begin
		pc_next = pc_plus2_o;
		if (opcode_i == OP_B && taken) begin
			pc_next = br_target;
		end else if (opcode_i == OP_BR && taken) begin
			pc_next = rs_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else if (en_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

	// Odd BR targets come from a bad register value
	a_pc_even: assert property (@(posedge clk) disable iff (!rst_n_i) !pc_q[0]);

endmodule

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/1ns

module cpu_alu (
	input  cpu_isa_pkg::opcode_e opcode_i,
	input  cpu_isa_pkg::word_t   a_i,
	input  cpu_isa_pkg::word_t   b_i,
	output cpu_isa_pkg::word_t   result_o,
	output cpu_isa_pkg::word_t   addr_o,
	output cpu_isa_pkg::flags_t  flags_o
);
	import cpu_isa_pkg::*;

	function automatic logic [3:0] sat_add4(input logic [3:0] x, input logic [3:0] y);
		logic [3:0] s;
		s = x + y;
		if (!x[3] && !y[3] && s[3]) begin
			return 4'h7;
		end
		if (x[3] && y[3] && !s[3]) begin
			return 4'h8;
		end
		return s;
	endfunction

	word_t               sum;
	word_t               diff;
	word_t               sat_val;
	logic                sum_ovf;
	logic                diff_ovf;
	logic                ovf;
	logic [2*WORD_W-1:0] rot_ext;

	assign sum      = a_i + b_i;
	assign diff     = a_i - b_i;
	assign sum_ovf  = (a_i[WORD_W-1] == b_i[WORD_W-1]) && (sum[WORD_W-1] != a_i[WORD_W-1]);
	assign diff_ovf = (a_i[WORD_W-1] != b_i[WORD_W-1]) && (diff[WORD_W-1] != a_i[WORD_W-1]);
	assign sat_val  = a_i[WORD_W-1] ? 16'h8000 : 16'h7fff; // Clamp toward the sign of a
	assign rot_ext  = {a_i, a_i} >> b_i[3:0];
	assign addr_o   = a_i + (b_i << 1); // Byte address from word offset

	always_comb begin
		ovf      = 1'b0;
		result_o = sum;
		case (opcode_i)
			OP_ADD: begin
				ovf      = sum_ovf;
				result_o = sum_ovf ? sat_val : sum;
			end
			OP_SUB: begin
				ovf      = diff_ovf;
				result_o = diff_ovf ? sat_val : diff;
			end
			OP_XOR: result_o = a_i ^ b_i;
			OP_SLL: result_o = a_i << b_i[3:0];
			OP_SRA: result_o = word_t'($signed(a_i) >>> b_i[3:0]);
			OP_ROR: result_o = rot_ext[WORD_W-1:0];
			OP_PADDSB: begin
				for (int i = 0; i < WORD_W / 4; i++) begin
					result_o[4*i +: 4] = sat_add4(a_i[4*i +: 4], b_i[4*i +: 4]);
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		flags_o         = '0;
		flags_o[FLAG_Z] = (result_o == '0);
		flags_o[FLAG_V] = ovf;
		flags_o[FLAG_N] = result_o[WORD_W-1];
	end

endmodule

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/1ns

module cpu_regfile (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  cpu_isa_pkg::reg_idx_t rs_i,
	input  cpu_isa_pkg::reg_idx_t rt_i,
	input  cpu_isa_pkg::reg_idx_t rd_i,
	input  logic                  we_i,
	input  cpu_isa_pkg::word_t    wdata_i,
	input  cpu_isa_pkg::reg_idx_t dbg_idx_i,
	output cpu_isa_pkg::word_t    rs_data_o,
	output cpu_isa_pkg::word_t    rt_data_o,
	output cpu_isa_pkg::word_t    dbg_data_o
);
	import cpu_isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && rd_i != '0) begin
			regs[rd_i] <= wdata_i;
		end
	end

	// Core reads see the old value, the write lands at the edge
	assign rs_data_o = (rs_i == '0) ? '0 : regs[rs_i];
	assign rt_data_o = (rt_i == '0) ? '0 : regs[rt_i];

	always_comb begin
		if (dbg_idx_i == '0) begin
			dbg_data_o = '0;
		end else if (we_i && dbg_idx_i == rd_i) begin
			dbg_data_o = wdata_i; // Bypass of a pending write
		end else begin
			dbg_data_o = regs[dbg_idx_i];
		end
	end

	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n_i) regs[0] == '0);

endmodule

// ==== verilog/cpu_decode.sv ====
`timescale 1ns/1ns

module cpu_decode (
	input  cpu_isa_pkg::word_t    instr_i,
	output cpu_isa_pkg::reg_idx_t rs_o,
	output cpu_isa_pkg::reg_idx_t rt_o,
	output cpu_isa_pkg::reg_idx_t rd_o,
	output cpu_isa_pkg::word_t    imm_o,
	output cpu_isa_pkg::imm8_t    byte_o,
	output cpu_isa_pkg::br_off_t  br_off_o,
	output cpu_isa_pkg::ccode_e   ccode_o,
	output cpu_isa_pkg::opcode_e  opcode_o,
	output logic                  reg_we_o,
	output logic                  flag_we_o,
	output logic                  alu_src_imm_o,
	output logic                  mem_we_o,
	output logic                  hlt_o,
	output cpu_isa_pkg::wb_sel_t  wb_sel_o
);
	import cpu_isa_pkg::*;

	assign opcode_o = opcode_e'(instr_i[WORD_W-1 -: OPCODE_W]);
	assign rd_o     = instr_i[11:8];
	assign imm_o    = {{(WORD_W-4){instr_i[3]}}, instr_i[3:0]};
	assign byte_o   = instr_i[BYTE_W-1:0];
	assign br_off_o = instr_i[BR_OFF_W-1:0];
	assign ccode_o  = ccode_e'(instr_i[11:9]);
	assign hlt_o    = (opcode_o == OP_HLT);

	always_comb begin
		rs_o          = instr_i[7:4];
		rt_o          = instr_i[3:0];
		reg_we_o      = 1'b0;
		flag_we_o     = 1'b0;
		alu_src_imm_o = 1'b0;
		mem_we_o      = 1'b0;
		wb_sel_o      = WB_ALU;
		case (opcode_o)
			OP_ADD, OP_SUB, OP_XOR: begin
				reg_we_o  = 1'b1;
				flag_we_o = 1'b1;
			end
			OP_SLL, OP_SRA, OP_ROR: begin
				reg_we_o      = 1'b1;
				flag_we_o     = 1'b1;
				alu_src_imm_o = 1'b1; // Shift amount from imm field
			end
			OP_PADDSB: reg_we_o = 1'b1;
			OP_LW: begin
				reg_we_o      = 1'b1;
				alu_src_imm_o = 1'b1;
				wb_sel_o      = WB_MEM;
			end
			OP_SW: begin
				rt_o          = instr_i[11:8]; // Store data register
				alu_src_imm_o = 1'b1;
				mem_we_o      = 1'b1;
			end
			OP_LLB, OP_LHB: begin
				rs_o     = instr_i[11:8]; // Old rd value for the merge
				reg_we_o = 1'b1;
				wb_sel_o = WB_BYTE;
			end
			OP_PCS: begin
				reg_we_o = 1'b1;
				wb_sel_o = WB_PCS;
			end
			default: ;
		endcase
	end

endmodule

// ==== verilog/cpu_mem_pkg.sv ====
package cpu_mem_pkg;

	localparam int MEM_IDX_W  = 8;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int APB_ADDR_W = 10;

	typedef logic [MEM_IDX_W-1:0]  mem_idx_t;
	typedef logic [APB_ADDR_W-1:0] apb_addr_t;

	// APB word address map, region picked by the top two bits
	localparam apb_addr_t APB_IMEM_BASE = 10'h000;
	localparam apb_addr_t APB_DMEM_BASE = 10'h100;
	localparam apb_addr_t APB_REG_BASE  = 10'h200;

endpackage

// ==== verilog/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	localparam int WORD_W    = 16;
	localparam int OPCODE_W  = 4;
	localparam int REG_IDX_W = 4;
	localparam int NUM_REGS  = 2 ** REG_IDX_W;
	localparam int BYTE_W    = 8;
	localparam int BR_OFF_W  = 9;
	localparam int CCODE_W   = 3;
	localparam int FLAGS_W   = 3;

	// Bit positions inside flags_t
	localparam int FLAG_N = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_Z = 2;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [BYTE_W-1:0]    imm8_t;
	typedef logic [BR_OFF_W-1:0]  br_off_t;
	typedef logic [FLAGS_W-1:0]   flags_t;
	typedef logic [1:0]           wb_sel_t;

	// Writeback source select
	localparam wb_sel_t WB_ALU  = 2'd0;
	localparam wb_sel_t WB_MEM  = 2'd1;
	localparam wb_sel_t WB_PCS  = 2'd2;
	localparam wb_sel_t WB_BYTE = 2'd3;

	typedef enum logic [OPCODE_W-1:0] {
		OP_ADD, OP_SUB, OP_XOR, OP_RSV,
		OP_SLL, OP_SRA, OP_ROR, OP_PADDSB,
		OP_LW, OP_SW, OP_LLB, OP_LHB,
		OP_B, OP_BR, OP_PCS, OP_HLT
	} opcode_e;

	typedef enum logic [CCODE_W-1:0] {
		CC_NE, CC_EQ, CC_GT, CC_LT, CC_GTE, CC_LTE, CC_OVF, CC_UNCOND
	} ccode_e;

endpackage
